/* rtl/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// integer datapath width, rv64.
`define XLEN 64

// register file index width.
`define REG_AW 5

// width of the *w word operations.
`define WLEN 32

`endif

/* rtl/exec_pkg.sv */
`include "exec_settings.svh"

package exec_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB     // lui.
    } alu_func_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_ALWAYS     // jal and jalr.
    } branch_func_t;

    typedef struct packed {
        alu_func_t    alufunc;
        branch_func_t branchfunc;
        logic         pcsrc;    // operand a is the pc.
        logic         immsrc;   // operand b is the immediate.
        logic         shiftw;   // word operands.
        logic         aluext;   // sign-extend the low word of the result.
    } control_t;

    // decoded instruction entering execute.
    typedef struct packed {
        logic        valid;
        word_t       pc;
        logic [31:0] raw_instr;
        control_t    ctl;
        word_t       srca;
        word_t       srcb;
        word_t       imm;
        reg_addr_t   ra1;
        reg_addr_t   ra2;
        reg_addr_t   dst;
    } decode_data_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        logic [31:0] raw_instr;
        control_t    ctl;
        reg_addr_t   ra1;
        reg_addr_t   ra2;
        reg_addr_t   dst;
        word_t       aluout;
        word_t       memwd;      // store data.
        logic        branch_taken;
        word_t       branch_target;
    } execute_data_t;

endpackage

/* rtl/alu.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module alu (
    input  exec_pkg::alu_func_t alufunc,
    input  exec_pkg::word_t     src1,
    input  exec_pkg::word_t     src2,
    output exec_pkg::word_t     aluout
);
    import exec_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = src2[SHAMT_W-1:0];  // rv64 uses six shift bits.
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alufunc)
            ALU_ADD: begin
                aluout = src1 + src2;
            end
            ALU_SUB: begin
                aluout = src1 - src2;
            end
            ALU_AND: begin
                aluout = src1 & src2;
            end
            ALU_OR: begin
                aluout = src1 | src2;
            end
            ALU_XOR: begin
                aluout = src1 ^ src2;
            end
            ALU_SLL: begin
                aluout = src1 << shamt;
            end
            ALU_SRL: begin
                aluout = src1 >> shamt;
            end
            ALU_SRA: begin
                aluout = word_t'($signed(src1) >>> shamt);
            end
            ALU_SLT: begin
                aluout = {{(`XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                aluout = {{(`XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_PASSB: begin
                aluout = src2;
            end
            default: begin
                aluout = '0;
            end
        endcase
    end

    // decode must never hand over an unused function code.
    always_comb begin
        if (!$isunknown(alufunc)) begin
            assert (alufunc <= ALU_PASSB)
                else $error("alu: illegal alufunc %0d", alufunc);
        end
    end

endmodule

/* rtl/branch_cmp.sv */
`timescale 1ns/1ps

module branch_cmp (
    input  exec_pkg::branch_func_t branchfunc,
    input  exec_pkg::word_t        src1,
    input  exec_pkg::word_t        src2,
    output logic                   branch_enable
);
    import exec_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = src1 == src2;
    assign lt  = $signed(src1) < $signed(src2);
    assign ltu = src1 < src2;

    always_comb begin
        case (branchfunc)
            BR_EQ: begin
                branch_enable = eq;
            end
            BR_NE: begin
                branch_enable = !eq;
            end
            BR_LT: begin
                branch_enable = lt;
            end
            BR_GE: begin
                branch_enable = !lt;
            end
            BR_LTU: begin
                branch_enable = ltu;
            end
            BR_GEU: begin
                branch_enable = !ltu;
            end
            BR_ALWAYS: begin
                branch_enable = 1'b1;   // jumps.
            end
            default: begin
                branch_enable = 1'b0;   // br_none.
            end
        endcase
    end

endmodule

/* rtl/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n,
    input  logic stall,
    input  logic flush,
    input  T     d,
    input  logic d_valid,
    output T     q,
    output logic q_valid
);

    T     data_r;
    logic valid_r;

    // stall wins over flush.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_r <= 1'b0;
        end else if (!stall) begin
            valid_r <= d_valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !flush) begin
            data_r <= d;
        end
    end

    // a bubble shows all zeros downstream.
    assign q       = valid_r ? data_r : '0;
    assign q_valid = valid_r;

    assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(q_valid))
        else $error("pipe_reg: q_valid unknown after reset");

endmodule

/* rtl/execute.sv */
`timescale 1ns/1ps
`include "exec_settings.svh"

module execute (
    input  exec_pkg::decode_data_t  data_d,
    input  logic                    fwd_a_en,
    input  logic                    fwd_b_en,
    input  exec_pkg::word_t         fwd_a_data,
    input  exec_pkg::word_t         fwd_b_data,
    output exec_pkg::execute_data_t data_e,
    output logic                    branch_enable
);
    import exec_pkg::*;

    localparam int SHW = $clog2(`WLEN);

    control_t ctl;
    word_t    src_a_reg;
    word_t    src_b_reg;
    word_t    src_a_sel;
    word_t    src_b_sel;
    word_t    src1;
    word_t    src2;
    word_t    alu_raw;
    logic     br_taken;

    assign ctl = data_d.ctl;

    assign src_a_reg = fwd_a_en ? fwd_a_data : data_d.srca;  // bypass beats regfile.
    assign src_b_reg = fwd_b_en ? fwd_b_data : data_d.srcb;

    assign src_a_sel = ctl.pcsrc  ? data_d.pc  : src_a_reg;   // auipc, jal.
    assign src_b_sel = ctl.immsrc ? data_d.imm : src_b_reg;

    // word shifts. srlw must pull zeros into bit 31, the others want the sign.
    always_comb begin
        src1 = src_a_sel;
        src2 = src_b_sel;
        if (ctl.shiftw) begin
            if (ctl.alufunc == ALU_SRL) begin
                src1 = {{(`XLEN-`WLEN){1'b0}}, src_a_sel[`WLEN-1:0]};
            end else begin
                src1 = {{(`XLEN-`WLEN){src_a_sel[`WLEN-1]}}, src_a_sel[`WLEN-1:0]};
            end
            src2 = {{(`XLEN-SHW){1'b0}}, src_b_sel[SHW-1:0]};
        end
    end

    alu u_alu (
        .alufunc (ctl.alufunc),
        .src1    (src1),
        .src2    (src2),
        .aluout  (alu_raw)
    );

    // conditions look at the register operands, never at pc or imm.
    branch_cmp u_branch_cmp (
        .branchfunc    (ctl.branchfunc),
        .src1          (src_a_reg),
        .src2          (src_b_reg),
        .branch_enable (br_taken)
    );

    assign branch_enable = data_d.valid & br_taken;

    always_comb begin
        data_e.valid     = data_d.valid;
        data_e.pc        = data_d.pc;
        data_e.raw_instr = data_d.raw_instr;
        data_e.ctl       = data_d.valid ? ctl : '0;
        data_e.ra1       = data_d.ra1;
        data_e.ra2       = data_d.ra2;
        data_e.dst       = data_d.dst;
        if (ctl.aluext) begin
            data_e.aluout = {{(`XLEN-`WLEN){alu_raw[`WLEN-1]}}, alu_raw[`WLEN-1:0]};
        end else begin
            data_e.aluout = alu_raw;
        end
        data_e.memwd         = src_b_reg;   // store data.
        data_e.branch_taken  = branch_enable;
        data_e.branch_target = branch_enable ? alu_raw : '0;  // pc + imm.
    end

    // only word ops and addw/subw may narrow the result.
    always_comb begin
        if (data_d.valid && !$isunknown(ctl)) begin
            assert (!ctl.aluext || ctl.shiftw || ctl.alufunc inside {ALU_ADD, ALU_SUB})
                else $error("execute: aluext with alufunc %0d", ctl.alufunc);
        end
    end

endmodule

/* rtl/execute_top.sv */
`timescale 1ns/1ps

module execute_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  stall,
    input  logic                  in_valid,
    input  exec_pkg::word_t       in_pc,
    input  logic [31:0]           in_raw_instr,
    input  exec_pkg::control_t    in_ctl,
    input  exec_pkg::word_t       in_srca,
    input  exec_pkg::word_t       in_srcb,
    input  exec_pkg::word_t       in_imm,
    input  exec_pkg::reg_addr_t   in_ra1,
    input  exec_pkg::reg_addr_t   in_ra2,
    input  exec_pkg::reg_addr_t   in_dst,
    input  logic                  fwd_a_en,
    input  logic                  fwd_b_en,
    input  exec_pkg::word_t       fwd_a_data,
    input  exec_pkg::word_t       fwd_b_data,
    output logic                  out_valid,
    output exec_pkg::word_t       out_pc,
    output exec_pkg::word_t       out_aluout,
    output exec_pkg::word_t       out_memwd,
    output exec_pkg::reg_addr_t   out_dst,
    output logic                  branch_taken,
    output exec_pkg::word_t       branch_target
);
    import exec_pkg::*;

    decode_data_t  id_ex_d;
    decode_data_t  id_ex_q;
    execute_data_t ex_mem_d;
    execute_data_t ex_mem_q;
    logic          id_ex_valid;
    logic          ex_mem_valid;
    logic          branch_enable;
    logic          flush_id_ex;

    always_comb begin
        id_ex_d.valid     = in_valid;
        id_ex_d.pc        = in_pc;
        id_ex_d.raw_instr = in_raw_instr;
        id_ex_d.ctl       = in_ctl;
        id_ex_d.srca      = in_srca;
        id_ex_d.srcb      = in_srcb;
        id_ex_d.imm       = in_imm;
        id_ex_d.ra1       = in_ra1;
        id_ex_d.ra2       = in_ra2;
        id_ex_d.dst       = in_dst;
    end

    // drop the instruction that enters behind a taken branch.
    assign flush_id_ex = id_ex_valid & branch_enable & ~stall;

    pipe_reg #(.T(decode_data_t)) u_id_ex (
        .clk     (clk),
        .arst_n  (arst_n),
        .stall   (stall),
        .flush   (flush_id_ex),
        .d       (id_ex_d),
        .d_valid (in_valid),
        .q       (id_ex_q),
        .q_valid (id_ex_valid)
    );

    execute u_execute (
        .data_d        (id_ex_q),
        .fwd_a_en      (fwd_a_en),
        .fwd_b_en      (fwd_b_en),
        .fwd_a_data    (fwd_a_data),
        .fwd_b_data    (fwd_b_data),
        .data_e        (ex_mem_d),
        .branch_enable (branch_enable)
    );

    pipe_reg #(.T(execute_data_t)) u_ex_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .stall   (stall),
        .flush   (1'b0),
        .d       (ex_mem_d),
        .d_valid (ex_mem_d.valid),
        .q       (ex_mem_q),
        .q_valid (ex_mem_valid)
    );

    assign out_valid     = ex_mem_valid;
    assign out_pc        = ex_mem_q.pc;
    assign out_aluout    = ex_mem_q.aluout;
    assign out_memwd     = ex_mem_q.memwd;
    assign out_dst       = ex_mem_q.dst;
    assign branch_taken  = ex_mem_q.branch_taken;
    assign branch_target = ex_mem_q.branch_target;

endmodule

/* dv/tb_execute_top.sv */
`timescale 1ns/1ps

module tb_execute_top;
    import exec_pkg::*;

    // about 3 cycles per single instruction, 4 per branch pair, plus reset and stall.
    localparam int EST_CYCLES = 14 + (66 + 20 + 9) * 3 + 32 * 4 + 12;
    localparam int MAX_CYCLES = 4 * EST_CYCLES;

    logic        clk;
    logic        arst_n;
    logic        stall;
    logic        in_valid;
    word_t       in_pc;
    logic [31:0] in_raw_instr;
    control_t    in_ctl;
    word_t       in_srca;
    word_t       in_srcb;
    word_t       in_imm;
    reg_addr_t   in_ra1;
    reg_addr_t   in_ra2;
    reg_addr_t   in_dst;
    logic        fwd_a_en;
    logic        fwd_b_en;
    word_t       fwd_a_data;
    word_t       fwd_b_data;
    logic        out_valid;
    word_t       out_pc;
    word_t       out_aluout;
    word_t       out_memwd;
    reg_addr_t   out_dst;
    logic        branch_taken;
    word_t       branch_target;

    logic [31:0] rng_state;
    int          cycles;
    int          errors;
    int          checks;
    int          tests;
    int          errors_at_start;
    string       cur_test;

    execute_top u_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic word_t rand_word();
        return {next_rand(), next_rand()};
    endfunction

    function automatic control_t make_ctl(alu_func_t f, branch_func_t b, logic pcsrc,
                                          logic immsrc, logic shiftw, logic aluext);
        control_t c;
        c.alufunc    = f;
        c.branchfunc = b;
        c.pcsrc      = pcsrc;
        c.immsrc     = immsrc;
        c.shiftw     = shiftw;
        c.aluext     = aluext;
        return c;
    endfunction

    // rv64i result from the effective register operands.
    function automatic word_t model_alu(control_t c, word_t ra, word_t rb, word_t pc, word_t imm);
        word_t       a;
        word_t       b;
        logic [31:0] w;
        a = c.pcsrc ? pc : ra;
        b = c.immsrc ? imm : rb;
        if (c.aluext) begin
            case (c.alufunc)
                ALU_SUB: w = a[31:0] - b[31:0];
                ALU_SLL: w = a[31:0] << b[4:0];
                ALU_SRL: w = a[31:0] >> b[4:0];
                ALU_SRA: w = $signed(a[31:0]) >>> b[4:0];
                default: w = a[31:0] + b[31:0];
            endcase
            return {{32{w[31]}}, w};  // *w results are sign-extended.
        end
        case (c.alufunc)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[5:0];
            ALU_SRL:  return a >> b[5:0];
            ALU_SRA:  return word_t'($signed(a) >>> b[5:0]);
            ALU_SLT:  return {63'd0, $signed(a) < $signed(b)};
            ALU_SLTU: return {63'd0, a < b};
            default:  return b;
        endcase
    endfunction

    function automatic logic model_branch(branch_func_t f, word_t a, word_t b);
        case (f)
            BR_EQ:     return a == b;
            BR_NE:     return a != b;
            BR_LT:     return $signed(a) < $signed(b);
            BR_GE:     return $signed(a) >= $signed(b);
            BR_LTU:    return a < b;
            BR_GEU:    return a >= b;
            BR_ALWAYS: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    task automatic compare_word(string what, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_addr(string what, reg_addr_t exp, reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_bit(string what, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic begin_test(string name);
        cur_test        = name;
        errors_at_start = errors;
        tests++;
    endtask

    task automatic finish_test();
        $display("test %-10s done, %0d errors", cur_test, errors - errors_at_start);
    endtask

    task automatic drive_instr(control_t c, word_t pc, word_t a, word_t b, word_t imm);
        in_valid     = 1'b1;
        in_ctl       = c;
        in_pc        = pc;
        in_srca      = a;
        in_srcb      = b;
        in_imm       = imm;
        in_raw_instr = next_rand();
        in_dst       = in_raw_instr[11:7];
        in_ra1       = in_raw_instr[19:15];
        in_ra2       = in_raw_instr[24:20];
    endtask

    // one instruction alone through both registers; forwarding during its execute cycle.
    task automatic run_instr(control_t c, word_t pc, word_t a, word_t b, word_t imm,
                             logic fa_en, word_t fa, logic fb_en, word_t fb);
        word_t     ra;
        word_t     rb;
        reg_addr_t dst;
        logic      taken;
        ra    = fa_en ? fa : a;
        rb    = fb_en ? fb : b;
        taken = model_branch(c.branchfunc, ra, rb);
        @(negedge clk);
        drive_instr(c, pc, a, b, imm);
        dst = in_dst;
        @(posedge clk);
        @(negedge clk);
        in_valid   = 1'b0;
        fwd_a_en   = fa_en;
        fwd_a_data = fa;
        fwd_b_en   = fb_en;
        fwd_b_data = fb;
        @(posedge clk);
        @(negedge clk);
        fwd_a_en = 1'b0;
        fwd_b_en = 1'b0;
        compare_bit("valid", 1'b1, out_valid);
        compare_word("pc", pc, out_pc);
        compare_addr("dst", dst, out_dst);
        compare_word("aluout", model_alu(c, ra, rb, pc, imm), out_aluout);
        compare_word("memwd", rb, out_memwd);
        compare_bit("taken", taken, branch_taken);
        compare_word("target", taken ? pc + imm : '0, branch_target);
    endtask

    task automatic test_reset();
        begin_test("reset");
        repeat (4) begin
            @(negedge clk);
            compare_bit("valid", 1'b0, out_valid);
            compare_bit("taken", 1'b0, branch_taken);
        end
        finish_test();
    endtask

    task automatic test_alu();
        begin_test("alu");
        for (int sel = 0; sel < 6; sel++) begin
            for (int f = 0; f <= 10; f++) begin
                run_instr(make_ctl(alu_func_t'(f[3:0]), BR_NONE, sel % 3 == 2, sel % 3 == 1,
                                   1'b0, 1'b0),
                          rand_word(), rand_word(), rand_word(), rand_word(),
                          1'b0, '0, 1'b0, '0);
            end
        end
        finish_test();
    endtask

    task automatic test_word();
        alu_func_t wf [5];
        begin_test("word");
        wf = '{ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA};
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 5; i++) begin
                run_instr(make_ctl(wf[i], BR_NONE, 1'b0, r == 3, i >= 2, 1'b1),
                          rand_word(), rand_word(), rand_word(), rand_word(),
                          1'b0, '0, 1'b0, '0);
            end
        end
        finish_test();
    endtask

    task automatic test_forwarding();
        begin_test("forwarding");
        for (int i = 0; i < 9; i++) begin
            run_instr(make_ctl(alu_func_t'(4'(i / 3)), BR_NONE, 1'b0, 1'b0, 1'b0, 1'b0),
                      rand_word(), rand_word(), rand_word(), '0,
                      i % 3 != 1, rand_word(), i % 3 != 0, rand_word());
        end
        finish_test();
    endtask

    task automatic test_branch();
        word_t pa [4];
        word_t pb [4];
        word_t pc;
        word_t imm;
        word_t fa;
        word_t fb;
        logic  taken;
        begin_test("branch");
        pa[0] = rand_word();
        pb[0] = pa[0];
        pa[1] = 64'hffff_ffff_ffff_fffb;  // less when signed, greater when unsigned.
        pb[1] = 64'd3;
        pa[2] = 64'd3;
        pb[2] = 64'd9;
        pa[3] = 64'd9;
        pb[3] = 64'd3;
        for (int f = 0; f < 8; f++) begin
            for (int p = 0; p < 4; p++) begin
                pc    = rand_word();
                imm   = rand_word();
                fa    = rand_word();
                fb    = rand_word();
                taken = model_branch(branch_func_t'(f[2:0]), pa[p], pb[p]);
                @(negedge clk);
                drive_instr(make_ctl(ALU_ADD, branch_func_t'(f[2:0]), 1'b1, 1'b1, 1'b0, 1'b0),
                            pc, pa[p], pb[p], imm);
                @(posedge clk);
                @(negedge clk);
                drive_instr(make_ctl(ALU_ADD, BR_NONE, 1'b0, 1'b0, 1'b0, 1'b0),
                            pc + 64'd4, fa, fb, '0);
                @(posedge clk);
                @(negedge clk);
                in_valid = 1'b0;
                compare_bit("valid", 1'b1, out_valid);
                compare_bit("taken", taken, branch_taken);
                compare_word("target", taken ? pc + imm : '0, branch_target);
                @(posedge clk);
                @(negedge clk);
                compare_bit("follower valid", !taken, out_valid);
                if (!taken) begin
                    compare_word("follower aluout", fa + fb, out_aluout);
                end
            end
        end
        finish_test();
    endtask

    task automatic test_stall();
        word_t a [2];
        word_t b [2];
        begin_test("stall");
        a[0] = rand_word();
        b[0] = rand_word();
        a[1] = rand_word();
        b[1] = rand_word();
        @(negedge clk);
        drive_instr(make_ctl(ALU_ADD, BR_NONE, 1'b0, 1'b0, 1'b0, 1'b0), rand_word(),
                    a[0], b[0], '0);
        @(posedge clk);
        @(negedge clk);
        drive_instr(make_ctl(ALU_XOR, BR_NONE, 1'b0, 1'b0, 1'b0, 1'b0), rand_word(),
                    a[1], b[1], '0);
        @(posedge clk);
        @(negedge clk);
        drive_instr(make_ctl(ALU_SUB, BR_NONE, 1'b0, 1'b0, 1'b0, 1'b0), rand_word(),
                    rand_word(), rand_word(), '0);
        stall = 1'b1;
        repeat (5) begin
            compare_bit("held valid", 1'b1, out_valid);
            compare_word("held aluout", a[0] + b[0], out_aluout);
            compare_word("held memwd", b[0], out_memwd);
            @(posedge clk);
            @(negedge clk);
        end
        stall    = 1'b0;
        in_valid = 1'b0;
        @(posedge clk);
        @(negedge clk);
        compare_bit("resumed valid", 1'b1, out_valid);
        compare_word("resumed aluout", a[1] ^ b[1], out_aluout);
        @(posedge clk);
        @(negedge clk);
        compare_bit("dropped valid", 1'b0, out_valid);
        finish_test();
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        stall        = 1'b0;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_raw_instr = '0;
        in_ctl       = '0;
        in_srca      = '0;
        in_srcb      = '0;
        in_imm       = '0;
        in_ra1       = '0;
        in_ra2       = '0;
        in_dst       = '0;
        fwd_a_en     = 1'b0;
        fwd_b_en     = 1'b0;
        fwd_a_data   = '0;
        fwd_b_data   = '0;
        rng_state    = 32'he5a2_207e;
        cycles       = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset();
        test_alu();
        test_word();
        test_forwarding();
        test_branch();
        test_stall();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+rtl
rtl/exec_pkg.sv
rtl/alu.sv
rtl/branch_cmp.sv
rtl/pipe_reg.sv
rtl/execute.sv
rtl/execute_top.sv
dv/tb_execute_top.sv

/* Makefile */
SRCS := $(filter-out +%,$(shell cat flist.f))

.PHONY: all run clean

all: run

obj_dir/Vtb_execute_top: flist.f $(SRCS) rtl/exec_settings.svh
	verilator --binary --timing --assert -f flist.f --top-module tb_execute_top -Mdir obj_dir

run: obj_dir/Vtb_execute_top
	./obj_dir/Vtb_execute_top | tee sim.log
	grep -qx '=== PASS ===' sim.log

clean:
	rm -rf obj_dir sim.log
